// ==== design/icache_pkg.sv ====
// icache package
// geometry of the two-port instruction cache and the structs that travel
// between its blocks
package icache_pkg;

  localparam int ip_w      = 32;
  localparam int sets      = 16;
  localparam int ways      = 2;
  localparam int quarter_w = 64;
  localparam int pre_w     = 4;
  localparam int line_w    = 256;
  localparam int half_w    = 128;

  // fetch address fields, offset bits 2..0 ignored
  localparam int q_lo   = 3;
  localparam int q_w    = 2;
  localparam int set_lo = 5;
  localparam int set_w  = 4;
  localparam int tag_lo = 9;
  localparam int tag_w  = 23;

  typedef struct packed {
    logic            valid;
    logic [ip_w-1:0] ip;
  } fetch_req_t;

  typedef struct packed {
    logic                 hit;
    logic [quarter_w-1:0] data;
    logic [pre_w-1:0]     predecode;
  } fetch_rsp_t;

  typedef struct packed {
    logic [ip_w-1:0]    ip;
    logic [half_w-1:0]  data;
    logic [2*pre_w-1:0] predecode;
  } fill_half_t;

  typedef struct packed {
    logic               valid;
    logic [ip_w-1:0]    ip;
    logic [line_w-1:0]  data;
    logic [4*pre_w-1:0] predecode;
  } line_wr_t;

  // one stored way, quarter q at data[q*quarter_w] and predecode[q*pre_w]
  typedef struct packed {
    logic [line_w-1:0]  data;
    logic [4*pre_w-1:0] predecode;
  } line_t;

  typedef struct packed {
    logic            valid;
    logic [ip_w-1:0] line_ip;
  } evict_t;

endpackage

// ==== design/icache_fill_stage.sv ====
// icache fill stage
// joins the two refill halves and issues a one-cycle line commit
`timescale 1ns/100ps

module icache_fill_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fill_first,
  input  icache_pkg::fill_half_t fill,
  output icache_pkg::line_wr_t   line_wr
);

  logic                             second_q;
  logic [icache_pkg::ip_w-1:0]      ip_q;
  logic [icache_pkg::half_w-1:0]    lo_q;
  logic [2*icache_pkg::pre_w-1:0]   pre_lo_q;

  // low half and address of the line
  always_ff @(posedge clk) begin
    if (fill_first) begin
      ip_q     <= fill.ip;
      lo_q     <= fill.data;
      pre_lo_q <= fill.predecode;
    end
    line_wr.ip        <= ip_q;
    line_wr.data      <= {fill.data, lo_q};
    line_wr.predecode <= {fill.predecode, pre_lo_q};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      second_q      <= 1'b0;
      line_wr.valid <= 1'b0;
    end else begin
      second_q      <= fill_first;
      // high half is on the bus this beat
      line_wr.valid <= second_q;
    end
  end

endmodule

// ==== design/icache_tag_array.sv ====
// icache tag array
// tags, valid and round-robin bits per set; registered hit and way for
// both fetch ports and the probe, victim choice and eviction report on fill
`timescale 1ns/100ps

module icache_tag_array (
  input  logic                      clk,
  input  logic                      rst,
  input  icache_pkg::fetch_req_t    req_a,
  input  icache_pkg::fetch_req_t    req_b,
  output logic                      hit_a,
  output logic                      hit_b,
  output logic                      way_a,
  output logic                      way_b,
  input  icache_pkg::line_wr_t      line_wr,
  output logic                      way_wr,
  input  logic                      inv,
  input  logic [icache_pkg::ip_w-1:0] inv_ip,
  input  logic                      probe,
  input  logic [icache_pkg::ip_w-1:0] probe_ip,
  output logic                      probe_hit,
  output icache_pkg::evict_t        evict
);

  logic [icache_pkg::tag_w-1:0]                         tag_q [icache_pkg::sets][icache_pkg::ways];
  logic [icache_pkg::sets-1:0][icache_pkg::ways-1:0]    valid_q;
  logic [icache_pkg::sets-1:0]                          rr_q;

  logic [icache_pkg::set_w-1:0] wr_set;
  logic [icache_pkg::tag_w-1:0] wr_tag;
  logic [icache_pkg::set_w-1:0] inv_set;
  logic [icache_pkg::ip_w-1:0]  look_ip [3];
  logic [2:0]                   look_hit;
  logic [2:0]                   look_way;

  assign wr_set  = line_wr.ip[icache_pkg::set_lo +: icache_pkg::set_w];
  assign wr_tag  = line_wr.ip[icache_pkg::tag_lo +: icache_pkg::tag_w];
  assign inv_set = inv_ip[icache_pkg::set_lo +: icache_pkg::set_w];

  // first invalid way, else the round-robin way
  always_comb begin
    way_wr = rr_q[wr_set];
    for (int w = icache_pkg::ways - 1; w >= 0; w--) begin
      if (!valid_q[wr_set][w]) way_wr = 1'(w);
    end
  end

  assign look_ip[0] = req_a.ip;
  assign look_ip[1] = req_b.ip;
  assign look_ip[2] = probe_ip;

  // the line being committed this cycle is forwarded into the compare
  always_comb begin
    logic [icache_pkg::set_w-1:0] s;
    logic [icache_pkg::tag_w-1:0] tag_e;
    logic                         val_e;
    for (int k = 0; k < 3; k++) begin
      look_hit[k] = 1'b0;
      look_way[k] = 1'b0;
      s = look_ip[k][icache_pkg::set_lo +: icache_pkg::set_w];
      for (int w = 0; w < icache_pkg::ways; w++) begin
        tag_e = tag_q[s][w];
        val_e = valid_q[s][w];
        if (line_wr.valid && s == wr_set && way_wr == 1'(w)) begin
          tag_e = wr_tag;
          val_e = 1'b1;
        end
        if (val_e && tag_e == look_ip[k][icache_pkg::tag_lo +: icache_pkg::tag_w]) begin
          look_hit[k] = 1'b1;
          look_way[k] = 1'(w);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    way_a <= look_way[0];
    way_b <= look_way[1];
    evict.line_ip <= {tag_q[wr_set][way_wr], wr_set, {icache_pkg::set_lo{1'b0}}};
    if (line_wr.valid) tag_q[wr_set][way_wr] <= wr_tag;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_a       <= 1'b0;
      hit_b       <= 1'b0;
      probe_hit   <= 1'b0;
      evict.valid <= 1'b0;
      valid_q     <= '0;
      rr_q        <= '0;
    end else begin
      hit_a       <= req_a.valid & look_hit[0];
      hit_b       <= req_b.valid & look_hit[1];
      probe_hit   <= probe & look_hit[2];
      evict.valid <= line_wr.valid & valid_q[wr_set][way_wr];
      if (line_wr.valid) begin
        valid_q[wr_set][way_wr] <= 1'b1;
        // only a full set advances the pointer
        if (&valid_q[wr_set]) rr_q[wr_set] <= ~rr_q[wr_set];
      end
      if (inv) begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
          if (tag_q[inv_set][w] == inv_ip[icache_pkg::tag_lo +: icache_pkg::tag_w])
            valid_q[inv_set][w] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== design/icache_data_array.sv ====
// icache data array
// line data and predecode per set and way, one write port and two
// registered read ports returning both ways
`timescale 1ns/100ps

module icache_data_array (
  input  logic                                   clk,
  input  icache_pkg::line_wr_t                   line_wr,
  input  logic                                   way_wr,
  input  icache_pkg::fetch_req_t                 req_a,
  input  icache_pkg::fetch_req_t                 req_b,
  output icache_pkg::line_t [icache_pkg::ways-1:0] lines_a,
  output icache_pkg::line_t [icache_pkg::ways-1:0] lines_b
);

  icache_pkg::line_t            mem [icache_pkg::sets][icache_pkg::ways];
  icache_pkg::line_t            wr_line;
  logic [icache_pkg::set_w-1:0] wr_set;
  logic [icache_pkg::set_w-1:0] set_a;
  logic [icache_pkg::set_w-1:0] set_b;

  assign wr_line = '{data: line_wr.data, predecode: line_wr.predecode};
  assign wr_set  = line_wr.ip[icache_pkg::set_lo +: icache_pkg::set_w];
  assign set_a   = req_a.ip[icache_pkg::set_lo +: icache_pkg::set_w];
  assign set_b   = req_b.ip[icache_pkg::set_lo +: icache_pkg::set_w];

  always_ff @(posedge clk) begin
    if (line_wr.valid) mem[wr_set][way_wr] <= wr_line;
    // same-edge commit is forwarded to the read
    for (int w = 0; w < icache_pkg::ways; w++) begin
      if (req_a.valid)
        lines_a[w] <= (line_wr.valid && set_a == wr_set && way_wr == 1'(w)) ?
                      wr_line : mem[set_a][w];
      if (req_b.valid)
        lines_b[w] <= (line_wr.valid && set_b == wr_set && way_wr == 1'(w)) ?
                      wr_line : mem[set_b][w];
    end
  end

endmodule

// ==== design/icache_read_port.sv ====
// icache read port
// picks the hit way and quarter from the array output and holds the
// fetch response under stall and exception
`timescale 1ns/100ps

module icache_read_port (
  input  logic                                   clk,
  input  logic                                   rst,
  input  icache_pkg::fetch_req_t                 req,
  input  logic                                   hit,
  input  logic                                   way,
  input  icache_pkg::line_t [icache_pkg::ways-1:0] lines,
  input  logic                                   fstall,
  input  logic                                   except,
  output icache_pkg::fetch_rsp_t                 rsp
);

  logic [icache_pkg::q_w-1:0]       q_q;
  logic                             v_q;
  icache_pkg::line_t                sel;
  logic [icache_pkg::quarter_w-1:0] sel_data;
  logic [icache_pkg::pre_w-1:0]     sel_pre;

  // quarter bits line up with the registered lookup
  always_ff @(posedge clk) begin
    if (req.valid) q_q <= req.ip[icache_pkg::q_lo +: icache_pkg::q_w];
  end

  assign sel      = lines[way];
  assign sel_data = sel.data[q_q*icache_pkg::quarter_w +: icache_pkg::quarter_w];
  assign sel_pre  = sel.predecode[q_q*icache_pkg::pre_w +: icache_pkg::pre_w];

  always_ff @(posedge clk) begin
    if (v_q && !fstall && !except) begin
      rsp.data      <= sel_data;
      rsp.predecode <= sel_pre;
    end
  end

  // output only reloads when a result arrives
  // except wins over both stall and a result arriving on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      v_q     <= 1'b0;
      rsp.hit <= 1'b0;
    end else begin
      v_q <= req.valid;
      if (except) begin
        rsp.hit <= 1'b0;
      end else if (v_q && !fstall) begin
        rsp.hit <= hit;
      end
    end
  end

endmodule

// ==== design/icache_top.sv ====
// icache top
// two-port instruction cache line store with fill, invalidate, probe and
// eviction report
`timescale 1ns/100ps

module icache_top (
  input  logic                        clk,
  input  logic                        rst,
  input  icache_pkg::fetch_req_t      req_a,
  input  logic                        fstall_a,
  input  logic                        except_a,
  output icache_pkg::fetch_rsp_t      rsp_a,
  input  icache_pkg::fetch_req_t      req_b,
  input  logic                        fstall_b,
  input  logic                        except_b,
  output icache_pkg::fetch_rsp_t      rsp_b,
  input  logic                        fill_first,
  input  icache_pkg::fill_half_t      fill,
  input  logic                        inv,
  input  logic [icache_pkg::ip_w-1:0] inv_ip,
  input  logic                        probe,
  input  logic [icache_pkg::ip_w-1:0] probe_ip,
  output logic                        probe_hit,
  output icache_pkg::evict_t          evict
);

  icache_pkg::line_wr_t                    line_wr;
  logic                                    way_wr;
  logic                                    hit_a;
  logic                                    hit_b;
  logic                                    way_a;
  logic                                    way_b;
  icache_pkg::line_t [icache_pkg::ways-1:0] lines_a;
  icache_pkg::line_t [icache_pkg::ways-1:0] lines_b;

  icache_fill_stage fill_stage (
    .clk        (clk),
    .rst        (rst),
    .fill_first (fill_first),
    .fill       (fill),
    .line_wr    (line_wr)
  );

  icache_tag_array tag_array (
    .clk       (clk),
    .rst       (rst),
    .req_a     (req_a),
    .req_b     (req_b),
    .hit_a     (hit_a),
    .hit_b     (hit_b),
    .way_a     (way_a),
    .way_b     (way_b),
    .line_wr   (line_wr),
    .way_wr    (way_wr),
    .inv       (inv),
    .inv_ip    (inv_ip),
    .probe     (probe),
    .probe_ip  (probe_ip),
    .probe_hit (probe_hit),
    .evict     (evict)
  );

  icache_data_array data_array (
    .clk     (clk),
    .line_wr (line_wr),
    .way_wr  (way_wr),
    .req_a   (req_a),
    .req_b   (req_b),
    .lines_a (lines_a),
    .lines_b (lines_b)
  );

  icache_read_port port_a (
    .clk    (clk),
    .rst    (rst),
    .req    (req_a),
    .hit    (hit_a),
    .way    (way_a),
    .lines  (lines_a),
    .fstall (fstall_a),
    .except (except_a),
    .rsp    (rsp_a)
  );

  icache_read_port port_b (
    .clk    (clk),
    .rst    (rst),
    .req    (req_b),
    .hit    (hit_b),
    .way    (way_b),
    .lines  (lines_b),
    .fstall (fstall_b),
    .except (except_b),
    .rsp    (rsp_b)
  );

endmodule

// ==== tb/icache_props.sv ====
// icache assertions
// eviction strobe width, except clearing the hit, outputs frozen under stall
`timescale 1ns/100ps

module icache_props (
  input logic                   clk,
  input logic                   rst,
  input icache_pkg::evict_t     evict,
  input icache_pkg::fetch_rsp_t rsp_a,
  input icache_pkg::fetch_rsp_t rsp_b,
  input logic                   fstall_a,
  input logic                   fstall_b,
  input logic                   except_a,
  input logic                   except_b
);

  evict_one_cycle: assert property (@(posedge clk) disable iff (rst)
    evict.valid |=> !evict.valid) else $error("evict valid held for more than one cycle");

  except_clears_a: assert property (@(posedge clk) disable iff (rst)
    except_a |=> !rsp_a.hit) else $error("port a hit after except");

  except_clears_b: assert property (@(posedge clk) disable iff (rst)
    except_b |=> !rsp_b.hit) else $error("port b hit after except");

  stall_holds_a: assert property (@(posedge clk) disable iff (rst)
    (fstall_a && !except_a) |=> $stable(rsp_a)) else $error("port a changed under stall");

  stall_holds_b: assert property (@(posedge clk) disable iff (rst)
    (fstall_b && !except_b) |=> $stable(rsp_b)) else $error("port b changed under stall");

endmodule

bind icache_top icache_props props (
  .clk      (clk),
  .rst      (rst),
  .evict    (evict),
  .rsp_a    (rsp_a),
  .rsp_b    (rsp_b),
  .fstall_a (fstall_a),
  .fstall_b (fstall_b),
  .except_a (except_a),
  .except_b (except_b)
);

// ==== tb/icache_tb.sv ====
// icache testbench
// drives both fetch ports, fills, invalidates and probes the cache and
// checks the responses against a reference model of tags and lines
`timescale 1ns/100ps

module icache_tb;

  logic                   clk;
  logic                   rst;
  icache_pkg::fetch_req_t req_a;
  icache_pkg::fetch_req_t req_b;
  logic                   fstall_a;
  logic                   fstall_b;
  logic                   except_a;
  logic                   except_b;
  icache_pkg::fetch_rsp_t rsp_a;
  icache_pkg::fetch_rsp_t rsp_b;
  logic                   fill_first;
  icache_pkg::fill_half_t fill;
  logic                   inv;
  logic [31:0]            inv_ip;
  logic                   probe;
  logic [31:0]            probe_ip;
  logic                   probe_hit;
  icache_pkg::evict_t     evict;

  // reference model of the cache contents
  logic [22:0]  tag_m [16][2];
  logic         val_m [16][2];
  logic         rr_m  [16];
  logic [255:0] dat_m [16][2];
  logic [15:0]  pre_m [16][2];

  // expected responses, two edges behind the request
  logic                   pend;
  logic                   pend_d1;
  logic                   pend_d2;
  icache_pkg::fetch_rsp_t exp_a;
  icache_pkg::fetch_rsp_t exp_b;
  icache_pkg::fetch_rsp_t exp_a_d1;
  icache_pkg::fetch_rsp_t exp_b_d1;
  icache_pkg::fetch_rsp_t exp_a_d2;
  icache_pkg::fetch_rsp_t exp_b_d2;

  int                     errors;
  int                     checks;
  int                     tests;
  int                     test_base;
  string                  cur_test;
  logic [31:0]            lines_q [$];
  logic [31:0]            ln [4];
  icache_pkg::fetch_rsp_t held;

  icache_top dut (
    .clk        (clk),
    .rst        (rst),
    .req_a      (req_a),
    .fstall_a   (fstall_a),
    .except_a   (except_a),
    .rsp_a      (rsp_a),
    .req_b      (req_b),
    .fstall_b   (fstall_b),
    .except_b   (except_b),
    .rsp_b      (rsp_b),
    .fill_first (fill_first),
    .fill       (fill),
    .inv        (inv),
    .inv_ip     (inv_ip),
    .probe      (probe),
    .probe_ip   (probe_ip),
    .probe_hit  (probe_hit),
    .evict      (evict)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // tag bits 31..9, set bits 8..5, quarter bits 4..3
  function automatic icache_pkg::fetch_rsp_t ref_rsp(input logic [31:0] ip);
    icache_pkg::fetch_rsp_t r;
    logic [3:0]             s;
    logic [1:0]             q;
    r = '0;
    s = ip[8:5];
    q = ip[4:3];
    for (int w = 0; w < 2; w++) begin
      if (val_m[s][w] && tag_m[s][w] == ip[31:9]) begin
        r.hit       = 1'b1;
        r.data      = dat_m[s][w][q*64 +: 64];
        r.predecode = pre_m[s][w][q*4 +: 4];
      end
    end
    return r;
  endfunction

  // random address in set s that the model does not hold
  function automatic logic [31:0] new_ip(input logic [3:0] s);
    logic [31:0]            ip;
    icache_pkg::fetch_rsp_t r;
    ip = '0;
    for (int i = 0; i < 8; i++) begin
      ip = {23'($urandom), s, 5'($urandom)};
      r  = ref_rsp(ip);
      if (!r.hit) break;
    end
    return ip;
  endfunction

  function automatic logic [31:0] any_quarter(input logic [31:0] ip);
    return {ip[31:5], 5'($urandom)};
  endfunction

  task automatic check_rsp(input string name, input icache_pkg::fetch_rsp_t exp,
                           input icache_pkg::fetch_rsp_t act);
    checks++;
    if (act.hit !== exp.hit ||
        (exp.hit && (act.data !== exp.data || act.predecode !== exp.predecode))) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_evict(input string name, input icache_pkg::evict_t exp,
                             input icache_pkg::evict_t act);
    checks++;
    if (act.valid !== exp.valid || (exp.valid && act.line_ip !== exp.line_ip)) begin
      errors++;
      $display("error %s evict: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s probe: expected %b, actual %b", name, exp, act);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pend_d1 <= 1'b0;
      pend_d2 <= 1'b0;
    end else begin
      pend_d1 <= pend;
      pend_d2 <= pend_d1;
    end
    exp_a_d1 <= exp_a;
    exp_b_d1 <= exp_b;
    exp_a_d2 <= exp_a_d1;
    exp_b_d2 <= exp_b_d1;
  end

  always @(negedge clk) begin
    if (pend_d2) begin
      check_rsp({cur_test, " port a"}, exp_a_d2, rsp_a);
      check_rsp({cur_test, " port b"}, exp_b_d2, rsp_b);
    end
  end

  task automatic issue(input logic [31:0] ip_a, input logic [31:0] ip_b, input logic track);
    @(posedge clk);
    req_a <= '{valid: 1'b1, ip: ip_a};
    req_b <= '{valid: 1'b1, ip: ip_b};
    pend  <= track;
    exp_a <= ref_rsp(ip_a);
    exp_b <= ref_rsp(ip_b);
    @(posedge clk);
    req_a.valid <= 1'b0;
    req_b.valid <= 1'b0;
    pend        <= 1'b0;
  endtask

  task automatic read_pair(input logic [31:0] ip_a, input logic [31:0] ip_b);
    issue(ip_a, ip_b, 1'b1);
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic fill_line(input logic [31:0] ip);
    logic [255:0]       d;
    logic [15:0]        p;
    logic [3:0]         s;
    logic               v;
    logic               seen;
    icache_pkg::evict_t exp;
    for (int i = 0; i < 8; i++) d[i*32 +: 32] = $urandom;
    p = 16'($urandom);
    s = ip[8:5];
    // lowest invalid way, else round robin
    v = rr_m[s];
    if (!val_m[s][1]) v = 1'b1;
    if (!val_m[s][0]) v = 1'b0;
    exp.valid   = val_m[s][v];
    exp.line_ip = {tag_m[s][v], s, 5'b0};
    if (val_m[s][0] && val_m[s][1]) rr_m[s] = ~rr_m[s];
    tag_m[s][v] = ip[31:9];
    val_m[s][v] = 1'b1;
    dat_m[s][v] = d;
    pre_m[s][v] = p;
    @(posedge clk);
    fill_first <= 1'b1;
    fill       <= '{ip: ip, data: d[127:0], predecode: p[7:0]};
    @(posedge clk);
    fill_first <= 1'b0;
    // address of the high half is a don't care
    fill       <= '{ip: $urandom, data: d[255:128], predecode: p[15:8]};
    seen = 1'b0;
    for (int i = 0; i < 6 && !seen; i++) begin
      @(negedge clk);
      seen = evict.valid;
    end
    if (exp.valid && !seen) begin
      errors++;
      $display("timeout in %s: no eviction reported after filling %h", cur_test, ip);
    end else begin
      check_evict(cur_test, exp, evict);
    end
  endtask

  task automatic inv_line(input logic [31:0] ip);
    @(posedge clk);
    inv    <= 1'b1;
    inv_ip <= ip;
    for (int w = 0; w < 2; w++) begin
      if (tag_m[ip[8:5]][w] == ip[31:9]) val_m[ip[8:5]][w] = 1'b0;
    end
    @(posedge clk);
    inv <= 1'b0;
  endtask

  task automatic probe_line(input logic [31:0] ip);
    icache_pkg::fetch_rsp_t r;
    r = ref_rsp(ip);
    @(posedge clk);
    probe    <= 1'b1;
    probe_ip <= ip;
    @(posedge clk);
    probe <= 1'b0;
    @(negedge clk);
    check_hit(cur_test, r.hit, probe_hit);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_base = errors;
  endtask

  task automatic end_test;
    @(posedge clk);
    tests++;
    $display("test %s finished, %0d errors", cur_test, errors - test_base);
  endtask

  initial begin
    void'($urandom(32'hc57f));
    rst        = 1'b1;
    req_a      = '0;
    req_b      = '0;
    fstall_a   = 1'b0;
    fstall_b   = 1'b0;
    except_a   = 1'b0;
    except_b   = 1'b0;
    fill_first = 1'b0;
    fill       = '0;
    inv        = 1'b0;
    inv_ip     = '0;
    probe      = 1'b0;
    probe_ip   = '0;
    pend       = 1'b0;
    exp_a      = '0;
    exp_b      = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    test_base  = 0;
    cur_test   = "reset";
    for (int s = 0; s < 16; s++) begin
      rr_m[s]     = 1'b0;
      val_m[s][0] = 1'b0;
      val_m[s][1] = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    start_test("reset miss");
    for (int i = 0; i < 4; i++) read_pair($urandom, $urandom);
    probe_line($urandom);
    end_test();

    // sets 0..7 only, set 12 stays empty for the conflict test
    start_test("fill and read");
    for (int i = 0; i < 8; i++) begin
      lines_q.push_back(new_ip(4'($urandom % 8)));
      fill_line(lines_q[i]);
    end
    for (int i = 0; i < 8; i++) read_pair(any_quarter(lines_q[i]), any_quarter(lines_q[7 - i]));
    end_test();

    start_test("set conflict");
    for (int i = 0; i < 4; i++) ln[i] = new_ip(4'd12);
    fill_line(ln[0]);
    fill_line(ln[1]);
    fill_line(ln[2]);
    read_pair(ln[0], ln[1]);
    read_pair(ln[2], any_quarter(ln[1]));
    fill_line(ln[3]);
    read_pair(ln[1], ln[3]);
    end_test();

    start_test("invalidate");
    inv_line(ln[2]);
    read_pair(ln[2], any_quarter(ln[3]));
    probe_line(ln[2]);
    probe_line(ln[3]);
    end_test();

    start_test("stall and except");
    @(posedge clk);
    req_a <= '{valid: 1'b1, ip: ln[3]};
    req_b <= '{valid: 1'b1, ip: ln[3]};
    pend  <= 1'b1;
    exp_a <= ref_rsp(ln[3]);
    exp_b <= ref_rsp(ln[3]);
    @(posedge clk);
    // this result arrives under stall and is dropped
    req_a <= '{valid: 1'b1, ip: lines_q[0]};
    req_b <= '{valid: 1'b1, ip: lines_q[1]};
    pend  <= 1'b0;
    @(posedge clk);
    req_a.valid <= 1'b0;
    req_b.valid <= 1'b0;
    fstall_a    <= 1'b1;
    fstall_b    <= 1'b1;
    held = ref_rsp(ln[3]);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_rsp({cur_test, " held a"}, held, rsp_a);
      check_rsp({cur_test, " held b"}, held, rsp_b);
    end
    @(posedge clk);
    fstall_a <= 1'b0;
    fstall_b <= 1'b0;
    issue(ln[3], ln[3], 1'b1);
    @(posedge clk);
    except_a <= 1'b1;
    except_b <= 1'b1;
    @(posedge clk);
    except_a <= 1'b0;
    except_b <= 1'b0;
    @(negedge clk);
    check_rsp({cur_test, " except a"}, '0, rsp_a);
    check_rsp({cur_test, " except b"}, '0, rsp_b);
    // except on the edge where the result lands
    issue(ln[3], ln[3], 1'b0);
    except_a <= 1'b1;
    except_b <= 1'b1;
    @(posedge clk);
    except_a <= 1'b0;
    except_b <= 1'b0;
    @(negedge clk);
    check_rsp({cur_test, " override a"}, '0, rsp_a);
    check_rsp({cur_test, " override b"}, '0, rsp_b);
    end_test();

    start_test("probe");
    probe_line(ln[3]);
    probe_line(ln[0]);
    for (int i = 0; i < 8; i++) probe_line(any_quarter(lines_q[i]));
    probe_line(new_ip(4'($urandom)));
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
design/icache_pkg.sv
design/icache_fill_stage.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_read_port.sv
design/icache_top.sv
tb/icache_props.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0
